// File: sdram_asserts.sv
`timescale 1ns/10ps

module sdram_asserts
  import sdram_cmd_pkg::*;
(
  input logic       cpu_clk,
  input logic       reset_n,
  input logic       init_done,
  input logic       ready,
  input logic       databus_oe,
  input logic       cs_n,
  input logic       ras_n,
  input logic       cas_n,
  input logic       we_n
);

  int         fail_count = 0;
  logic [3:0] cmd;

  assign cmd = {cs_n, ras_n, cas_n, we_n};

  ready_single_pulse: assert property (
    @(posedge cpu_clk) disable iff (!reset_n) ready |=> !ready)
  else begin
    $error("ready stayed high for two cycles");
    fail_count++;
  end

  oe_only_on_write: assert property (
    @(posedge cpu_clk) disable iff (!reset_n) databus_oe |-> cmd == CMD_WRITE)
  else begin
    $error("databus_oe high without a WRITE command");
    fail_count++;
  end

  // Only the power-up commands may appear before init_done.
  init_cmds_only: assert property (
    @(posedge cpu_clk) disable iff (!reset_n)
    !init_done |-> cmd inside {CMD_NOP, CMD_DESL, CMD_PRECHARGE, CMD_REFRESH, CMD_MRS})
  else begin
    $error("access command issued before init_done");
    fail_count++;
  end

endmodule

bind sdram_cmd_fsm sdram_asserts u_asserts (
  .cpu_clk    (cpu_clk),
  .reset_n    (reset_n),
  .init_done  (init_done),
  .ready      (ready),
  .databus_oe (databus_oe),
  .cs_n       (cs_n),
  .ras_n      (ras_n),
  .cas_n      (cas_n),
  .we_n       (we_n)
);

// File: sdram_checker.sv
`timescale 1ns/10ps

module sdram_checker
  import sdram_cmd_pkg::*;
  import sdram_timing_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        reset_n,
  input  logic        init_done,
  input  logic        read,
  input  logic        write,
  input  logic [24:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0]  be,
  input  logic [31:0] data_out,
  input  logic        ready,
  input  logic        wait_out,
  input  logic        cfg_write,
  input  logic        cfg_sel,
  input  logic [15:0] cfg_wdata,
  input  logic        cs_n,
  input  logic        ras_n,
  input  logic        cas_n,
  input  logic        we_n,
  input  logic [1:0]  ba,
  input  logic [12:0] addrbus_out,
  input  logic [3:0]  dqm,
  input  logic [31:0] databus_out,
  input  logic        databus_oe,
  input  logic [31:0] exp_data,
  input  logic        measure,
  output logic [31:0] databus_in,
  output int          error_count,
  output int          test_count
);

  logic [31:0]      mem [logic [24:0]];
  logic [31:0]      shadow [logic [24:0]];
  logic [12:0]      open_row [4];
  sdram_cmd_t       cmd;
  sdram_addr_word_t mrs_word;
  logic [2:0]       model_cl = 3'd2;
  logic [1:0]       exp_cl = 2'd2;
  logic [15:0]      interval = 16'd390;
  logic [31:0]      rd_data = '0;
  logic [3:0]       rd_wait = '0;
  logic             rd_go = 1'b0;
  logic             init_done_q = 1'b0;
  logic             measure_q = 1'b0;
  logic             wait_bad = 1'b0;
  int               init_pre = 0;
  int               init_ref = 0;
  int               init_mrs = 0;
  int               mrs_count = 0;
  int               exp_mrs = 0;
  int               win_cycles = 0;
  int               win_refs = 0;

  assign cmd = sdram_cmd_t'({cs_n, ras_n, cas_n, we_n});
  assign mrs_word = addrbus_out;

  initial begin
    databus_in  = '0;
    error_count = 0;
    test_count  = 0;
  end

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  en);
    logic [31:0] r;
    r = old_w;
    for (int i = 0; i < 4; i++)
      if (en[i])
        r[8*i +: 8] = new_w[8*i +: 8];
    return r;
  endfunction

  task automatic report_error(input string msg);
    $display("[ERROR] t=%0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic finish_test(input string name, input bit ok);
    test_count++;
    $display("Test %0d %s: %s", test_count, name, ok ? "ok" : "failed");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // SDRAM model and result comparison on the rising edge.
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge cpu_clk) begin : watch
    logic [24:0] key;
    logic [31:0] want;
    int          lim;
    bit          ok;
    rd_go = 1'b0;
    if (reset_n) begin
      if (rd_wait != 4'd0) begin
        rd_wait = rd_wait - 4'd1;
        if (rd_wait == 4'd0)
          rd_go = 1'b1;
      end
      if (!init_done && !wait_out)
        wait_bad = 1'b1;
      // Refresh and MRS after power-up must also hold the CPU off.
      if (init_done && (cmd == CMD_REFRESH || cmd == CMD_MRS) && !wait_out)
        report_error("wait_out low during a refresh or MRS");
      key = {ba, open_row[ba], addrbus_out[COL_MSB:0]};
      case (cmd)
        CMD_ACTIVATE: open_row[ba] = addrbus_out;
        CMD_WRITE: begin
          if (!databus_oe)
            report_error("WRITE issued with databus_oe low");
          want = mem.exists(key) ? mem[key] : 32'h0;
          mem[key] = merge_bytes(want, databus_out, ~dqm);
        end
        CMD_READ: begin
          rd_data = mem.exists(key) ? mem[key] : 32'h0;
          rd_wait = {1'b0, model_cl};
        end
        CMD_MRS: begin
          model_cl = mrs_word.mode.cas_lat;
          if (init_done)
            mrs_count++;
          else
            init_mrs++;
        end
        CMD_REFRESH: begin
          if (!init_done)
            init_ref++;
          else if (measure)
            win_refs++;
        end
        CMD_PRECHARGE: begin
          if (!init_done && addrbus_out[10])
            init_pre++;
        end
        default: ;
      endcase

      if (init_done && !init_done_q) begin
        ok = (init_pre == 1) && (init_ref == 8) && (init_mrs == 1) && (model_cl == 3'd2);
        if (!ok)
          report_error($sformatf("power-up gave %0d PRECHARGE, %0d REFRESH, %0d MRS, CL %0d",
                                 init_pre, init_ref, init_mrs, model_cl));
        if (wait_bad)
          report_error("wait_out dropped before init_done");
        finish_test("power-up sequence", ok && !wait_bad);
      end
      init_done_q = init_done;

      // Configuration writes as the CPU side sees them.
      if (cfg_write) begin
        if (!cfg_sel) begin
          interval = cfg_wdata;
        end else if (cfg_wdata == 16'd2 || cfg_wdata == 16'd3) begin
          if (cfg_wdata[1:0] != exp_cl)
            exp_mrs++;
          exp_cl = cfg_wdata[1:0];
        end
      end

      if (ready && write) begin
        want = shadow.exists(address) ? shadow[address] : 32'h0;
        shadow[address] = merge_bytes(want, data_in, be);
        finish_test($sformatf("write 0x%h be %b", address, be), 1'b1);
      end else if (ready && read) begin
        want = shadow.exists(address) ? shadow[address] : 32'h0;
        ok = (data_out === want) && (data_out === exp_data);
        if (!ok)
          report_error($sformatf("read 0x%h gave 0x%h, shadow 0x%h, table 0x%h",
                                 address, data_out, want, exp_data));
        if (mrs_count != exp_mrs || model_cl != {1'b0, exp_cl}) begin
          ok = 1'b0;
          report_error($sformatf("%0d MRS with CL %0d, expected %0d with CL %0d",
                                 mrs_count, model_cl, exp_mrs, exp_cl));
        end
        finish_test($sformatf("read 0x%h", address), ok);
      end else if (ready) begin
        report_error("ready pulsed with no request pending");
      end

      // Refresh rate over an idle window.
      if (measure) begin
        win_cycles++;
      end else if (measure_q) begin
        lim = win_cycles / int'(interval);
        ok = (win_refs >= lim - 1) && (win_refs <= lim + 1);
        if (!ok)
          report_error($sformatf("%0d REFRESH in %0d cycles, interval %0d",
                                 win_refs, win_cycles, interval));
        finish_test($sformatf("refresh window, interval %0d", interval), ok);
        win_cycles = 0;
        win_refs   = 0;
      end
      measure_q = measure;
    end
  end

  // Read data goes onto the bus half a cycle before the sequencer samples it.
  always @(negedge cpu_clk) begin
    if (rd_go)
      databus_in = rd_data;
  end

endmodule

// File: sdram_cmd_fsm.sv
`timescale 1ns/10ps

module sdram_cmd_fsm
  import sdram_cmd_pkg::*;
  import sdram_timing_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        reset_n,
  input  logic        read,
  input  logic        write,
  input  logic [24:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0]  be,
  input  logic [1:0]  cas_latency,
  input  logic        mode_reload,
  input  logic        refresh_req,
  input  logic [31:0] databus_in,
  output logic        ready,
  output logic [31:0] data_out,
  output logic        wait_out,
  output logic        init_done,
  output logic        mode_ack,
  output logic        refresh_ack,
  output logic        cs_n,
  output logic        ras_n,
  output logic        cas_n,
  output logic        we_n,
  output logic [1:0]  ba,
  output logic [12:0] addrbus_out,
  output logic [3:0]  dqm,
  output logic [31:0] databus_out,
  output logic        databus_oe
);

  fsm_state_t       state;
  logic [3:0]       delay;
  sdram_cmd_t       cmd_q;
  sdram_cmd_t       init_cmd;
  logic [12:0]      init_addr;
  sdram_addr_word_t init_word;
  sdram_addr_word_t mode_word;
  logic             op_read;
  logic [1:0]       mrs_cl;
  logic             issue_rw;
  logic             capture_now;

  sdram_init_seq u_init (
    .cpu_clk     (cpu_clk),
    .reset_n     (reset_n),
    .cas_latency (cas_latency),
    .init_cmd    (init_cmd),
    .init_addr   (init_addr),
    .init_done   (init_done)
  );

  assign init_word = init_addr;

  always_comb begin
    mode_word = '0;
    mode_word.mode.cas_lat = {1'b0, cas_latency};
  end

  assign issue_rw    = (state == ST_ACTIVATE) && (delay == 4'd0);
  assign capture_now = (state == ST_CAPTURE) && (delay == 4'd0);
  assign wait_out    = !init_done || (state == ST_REFRESH) || (state == ST_MODE);
  assign {cs_n, ras_n, cas_n, we_n} = cmd_q;

  ////////////////////////////////////////////////////////////////////////////
  // Command sequencer. All pin outputs come straight from registers.
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= ST_INIT;
      delay       <= '0;
      cmd_q       <= CMD_NOP;
      ba          <= '0;
      addrbus_out <= '0;
      dqm         <= 4'hf;
      databus_oe  <= 1'b0;
      ready       <= 1'b0;
      mode_ack    <= 1'b0;
      refresh_ack <= 1'b0;
      op_read     <= 1'b0;
      mrs_cl      <= CAS_LATENCY_RESET;
    end else begin
      cmd_q       <= CMD_NOP;
      databus_oe  <= 1'b0;
      ready       <= 1'b0;
      mode_ack    <= 1'b0;
      refresh_ack <= 1'b0;
      case (state)
        ST_INIT: begin
          cmd_q       <= init_cmd;
          ba          <= 2'b00;
          addrbus_out <= init_addr;
          if (init_cmd == CMD_MRS)
            mrs_cl <= init_word.mode.cas_lat[1:0];
          if (init_done)
            state <= ST_IDLE;
        end
        ST_IDLE: begin
          // Refresh first, then mode reload, then the CPU.
          if (refresh_req) begin
            cmd_q       <= CMD_REFRESH;
            refresh_ack <= 1'b1;
            delay       <= T_RFC;
            state       <= ST_REFRESH;
          end else if (mode_reload) begin
            cmd_q       <= CMD_MRS;
            ba          <= 2'b00;
            addrbus_out <= mode_word.word;
            mode_ack    <= 1'b1;
            mrs_cl      <= cas_latency;
            delay       <= T_MRD;
            state       <= ST_MODE;
          end else if (read || write) begin
            cmd_q       <= CMD_ACTIVATE;
            ba          <= address[BANK_MSB:BANK_LSB];
            addrbus_out <= address[ROW_MSB:ROW_LSB];
            op_read     <= read;
            delay       <= T_RCD - 4'd1;
            state       <= ST_ACTIVATE;
          end
        end
        ST_ACTIVATE: begin
          if (issue_rw) begin
            cmd_q       <= op_read ? CMD_READ : CMD_WRITE;
            addrbus_out <= {2'b00, 1'b1, address[COL_MSB:0]};  // A10 auto-precharge
            dqm         <= op_read ? 4'h0 : ~be;
            databus_oe  <= !op_read;
            state       <= ST_ACCESS;
          end else begin
            delay <= delay - 4'd1;
          end
        end
        ST_ACCESS: begin
          if (op_read) begin
            delay <= {2'b00, mrs_cl};
            state <= ST_CAPTURE;
          end else begin
            dqm   <= 4'hf;
            ready <= 1'b1;
            delay <= T_WR_RECOVER;
            state <= ST_RECOVER;
          end
        end
        ST_CAPTURE: begin
          if (capture_now) begin
            dqm   <= 4'hf;
            ready <= 1'b1;
            delay <= T_RP;
            state <= ST_RECOVER;
          end else begin
            delay <= delay - 4'd1;
          end
        end
        ST_RECOVER, ST_REFRESH, ST_MODE: begin
          if (delay == 4'd0)
            state <= ST_IDLE;
          else
            delay <= delay - 4'd1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Write data goes out with the WRITE command, read data lands with ready.
  always_ff @(posedge cpu_clk) begin
    if (issue_rw && !op_read)
      databus_out <= data_in;
    if (capture_now)
      data_out <= databus_in;
  end

endmodule

// File: sdram_cmd_pkg.sv
package sdram_cmd_pkg;

  // Pin order is {cs_n, ras_n, cas_n, we_n}.
  typedef enum logic [3:0] {
    CMD_MRS       = 4'h0,
    CMD_REFRESH   = 4'h1,
    CMD_PRECHARGE = 4'h2,
    CMD_ACTIVATE  = 4'h3,
    CMD_WRITE     = 4'h4,
    CMD_READ      = 4'h5,
    CMD_NOP       = 4'h7,
    CMD_DESL      = 4'hf
  } sdram_cmd_t;

  // Address bus word, either a row/column address or the mode register layout.
  typedef union packed {
    logic [12:0] word;
    struct packed {
      logic [2:0] reserved;
      logic       wb_mode;
      logic [1:0] op_mode;
      logic [2:0] cas_lat;
      logic       burst_type;
      logic [2:0] burst_len;
    } mode;
  } sdram_addr_word_t;

  typedef enum logic [3:0] {
    ST_INIT, ST_INIT_PRECHARGE, ST_INIT_REFRESH, ST_INIT_MRS,
    ST_IDLE, ST_ACTIVATE, ST_ACCESS, ST_CAPTURE, ST_RECOVER, ST_REFRESH, ST_MODE
  } fsm_state_t;

endpackage

// File: sdram_config_regs.sv
`timescale 1ns/10ps

module sdram_config_regs
  import sdram_timing_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        reset_n,
  input  logic        cfg_write,
  input  logic        cfg_sel,
  input  logic [15:0] cfg_wdata,
  input  logic        mode_ack,
  output logic [15:0] refresh_interval,
  output logic [1:0]  cas_latency,
  output logic        mode_reload
);

  logic cl_valid;

  // Only latencies 2 and 3 are supported.
  assign cl_valid = (cfg_wdata == 16'd2) || (cfg_wdata == 16'd3);

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      refresh_interval <= REFRESH_INTERVAL_RESET;
      cas_latency      <= CAS_LATENCY_RESET;
      mode_reload      <= 1'b0;
    end else begin
      if (mode_ack)
        mode_reload <= 1'b0;
      if (cfg_write) begin
        if (!cfg_sel) begin
          refresh_interval <= cfg_wdata;
        end else if (cl_valid) begin
          cas_latency <= cfg_wdata[1:0];
          // A new latency needs a fresh MRS.
          if (cfg_wdata[1:0] != cas_latency)
            mode_reload <= 1'b1;
        end
      end
    end
  end

endmodule

// File: sdram_controller.sv
`timescale 1ns/10ps

module sdram_controller (
  input  logic        cpu_clk,
  input  logic        reset_n,
  // CPU bus.
  input  logic        read,
  input  logic        write,
  input  logic [24:0] address,
  input  logic [31:0] data_in,
  input  logic [3:0]  be,
  output logic [31:0] data_out,
  output logic        ready,
  output logic        wait_out,
  // Configuration.
  input  logic        cfg_write,
  input  logic        cfg_sel,
  input  logic [15:0] cfg_wdata,
  // SDRAM pins.
  output logic        cs_n,
  output logic        ras_n,
  output logic        cas_n,
  output logic        we_n,
  output logic [1:0]  ba,
  output logic [12:0] addrbus_out,
  output logic [3:0]  dqm,
  output logic [31:0] databus_out,
  output logic        databus_oe,
  input  logic [31:0] databus_in
);

  logic [15:0] refresh_interval;
  logic [1:0]  cas_latency;
  logic        mode_reload;
  logic        mode_ack;
  logic        refresh_req;
  logic        refresh_ack;
  logic        init_done;

  sdram_config_regs u_config (
    .cpu_clk          (cpu_clk),
    .reset_n          (reset_n),
    .cfg_write        (cfg_write),
    .cfg_sel          (cfg_sel),
    .cfg_wdata        (cfg_wdata),
    .mode_ack         (mode_ack),
    .refresh_interval (refresh_interval),
    .cas_latency      (cas_latency),
    .mode_reload      (mode_reload)
  );

  sdram_refresh_timer u_refresh (
    .cpu_clk          (cpu_clk),
    .reset_n          (reset_n),
    .init_done        (init_done),
    .refresh_interval (refresh_interval),
    .refresh_ack      (refresh_ack),
    .refresh_req      (refresh_req)
  );

  sdram_cmd_fsm u_fsm (
    .cpu_clk     (cpu_clk),
    .reset_n     (reset_n),
    .read        (read),
    .write       (write),
    .address     (address),
    .data_in     (data_in),
    .be          (be),
    .cas_latency (cas_latency),
    .mode_reload (mode_reload),
    .refresh_req (refresh_req),
    .databus_in  (databus_in),
    .ready       (ready),
    .data_out    (data_out),
    .wait_out    (wait_out),
    .init_done   (init_done),
    .mode_ack    (mode_ack),
    .refresh_ack (refresh_ack),
    .cs_n        (cs_n),
    .ras_n       (ras_n),
    .cas_n       (cas_n),
    .we_n        (we_n),
    .ba          (ba),
    .addrbus_out (addrbus_out),
    .dqm         (dqm),
    .databus_out (databus_out),
    .databus_oe  (databus_oe)
  );

endmodule

// File: sdram_init_seq.sv
`timescale 1ns/10ps

module sdram_init_seq
  import sdram_cmd_pkg::*;
  import sdram_timing_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        reset_n,
  input  logic [1:0]  cas_latency,
  output sdram_cmd_t  init_cmd,
  output logic [12:0] init_addr,
  output logic        init_done
);

  fsm_state_t       state;
  logic [15:0]      delay;
  logic [3:0]       refs_left;
  sdram_addr_word_t mode_word;

  // Burst length 1, sequential, programmed write burst.
  always_comb begin
    mode_word = '0;
    mode_word.mode.cas_lat = {1'b0, cas_latency};
  end

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= ST_INIT;
      delay     <= INIT_WAIT_CYCLES - 16'd1;
      refs_left <= '0;
      init_cmd  <= CMD_NOP;
      init_addr <= '0;
      init_done <= 1'b0;
    end else begin
      init_cmd  <= CMD_NOP;
      init_addr <= '0;
      case (state)
        ST_INIT: begin
          if (delay == 16'd0) begin
            init_cmd  <= CMD_PRECHARGE;
            init_addr <= 13'h0400;  // A10 selects all banks
            delay     <= 16'(T_RP);
            state     <= ST_INIT_PRECHARGE;
          end else begin
            delay <= delay - 16'd1;
          end
        end
        ST_INIT_PRECHARGE: begin
          if (delay == 16'd0) begin
            init_cmd  <= CMD_REFRESH;
            refs_left <= INIT_REFRESHES - 4'd1;
            delay     <= 16'(T_RFC);
            state     <= ST_INIT_REFRESH;
          end else begin
            delay <= delay - 16'd1;
          end
        end
        ST_INIT_REFRESH: begin
          if (delay != 16'd0) begin
            delay <= delay - 16'd1;
          end else if (refs_left == 4'd0) begin
            init_cmd  <= CMD_MRS;
            init_addr <= mode_word.word;
            delay     <= 16'(T_MRD);
            state     <= ST_INIT_MRS;
          end else begin
            init_cmd  <= CMD_REFRESH;
            refs_left <= refs_left - 4'd1;
            delay     <= 16'(T_RFC);
          end
        end
        ST_INIT_MRS: begin
          if (delay == 16'd0) begin
            init_done <= 1'b1;
            state     <= ST_IDLE;
          end else begin
            delay <= delay - 16'd1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: sdram_refresh_timer.sv
`timescale 1ns/10ps

module sdram_refresh_timer
  import sdram_timing_pkg::*;
(
  input  logic        cpu_clk,
  input  logic        reset_n,
  input  logic        init_done,
  input  logic [15:0] refresh_interval,
  input  logic        refresh_ack,
  output logic        refresh_req
);

  logic [15:0] count;
  logic        init_done_q;

  always_ff @(posedge cpu_clk or negedge reset_n) begin
    if (!reset_n) begin
      count       <= REFRESH_INTERVAL_RESET;
      init_done_q <= 1'b0;
      refresh_req <= 1'b0;
    end else begin
      init_done_q <= init_done;
      // Reload while idle, on init_done rising and after each refresh.
      if (!(init_done && init_done_q) || refresh_ack) begin
        count       <= refresh_interval;
        refresh_req <= 1'b0;
      end else if (count == 16'd0) begin
        refresh_req <= 1'b1;
      end else begin
        count <= count - 16'd1;
      end
    end
  end

endmodule

// File: sdram_tb.sv
`timescale 1ns/10ps

module sdram_tb;

  localparam int INIT_TIMEOUT  = 2000;
  localparam int READY_TIMEOUT = 200;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CFG, OP_IDLE} op_t;

  // For OP_CFG addr[0] is cfg_sel. For OP_IDLE data is the cycle count and
  // be[0] marks a measured refresh window.
  typedef struct {
    op_t         op;
    logic [24:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic [31:0] exp_rd;
  } entry_t;

  logic        cpu_clk;
  logic        reset_n;
  logic        read;
  logic        write;
  logic [24:0] address;
  logic [31:0] data_in;
  logic [3:0]  be;
  logic [31:0] data_out;
  logic        ready;
  logic        wait_out;
  logic        cfg_write;
  logic        cfg_sel;
  logic [15:0] cfg_wdata;
  logic        cs_n;
  logic        ras_n;
  logic        cas_n;
  logic        we_n;
  logic [1:0]  ba;
  logic [12:0] addrbus_out;
  logic [3:0]  dqm;
  logic [31:0] databus_out;
  logic        databus_oe;
  logic [31:0] databus_in;
  logic        init_done;
  logic [31:0] exp_data;
  logic        measure;
  logic [31:0] lfsr_state;
  entry_t      stim_q[$];
  int          tb_errors;
  int          chk_errors;
  int          chk_tests;

  sdram_controller uut (.*);

  assign init_done = uut.init_done;

  sdram_checker u_checker (
    .cpu_clk, .reset_n, .init_done, .read, .write, .address, .data_in, .be,
    .data_out, .ready, .wait_out, .cfg_write, .cfg_sel, .cfg_wdata,
    .cs_n, .ras_n, .cas_n, .we_n, .ba, .addrbus_out, .dqm, .databus_out,
    .databus_oe, .exp_data, .measure, .databus_in,
    .error_count (chk_errors),
    .test_count  (chk_tests)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #4 cpu_clk = ~cpu_clk;
  end

  // Fibonacci LFSR, taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 32; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [31:0] merge_enabled(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  en);
    logic [31:0] r;
    r = old_w;
    for (int k = 0; k < 4; k++)
      if (en[k])
        r[8*k +: 8] = new_w[8*k +: 8];
    return r;
  endfunction

  task automatic add_entry(input op_t op, input logic [24:0] addr, input logic [3:0] be_v,
                           input logic [31:0] data, input logic [31:0] exp_rd);
    entry_t e;
    e.op     = op;
    e.addr   = addr;
    e.be     = be_v;
    e.data   = data;
    e.exp_rd = exp_rd;
    stim_q.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table. Address is {bank, row, column}.
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_table();
    logic [31:0] d [9];
    logic [31:0] m0;
    logic [31:0] m1;
    logic [24:0] a0;
    logic [24:0] a1;
    logic [24:0] a2;
    logic [24:0] a3;
    logic [24:0] a4;
    a0 = {2'd0, 13'd0, 10'h010};
    a1 = {2'd1, 13'd0, 10'h010};
    a2 = {2'd0, 13'd5, 10'h010};
    a3 = {2'd0, 13'd0, 10'h011};
    a4 = {2'd3, 13'h1abc, 10'h3ff};
    for (int k = 0; k < 9; k++)
      d[k] = random_word();
    m0 = merge_enabled(d[0], d[4], 4'b0101);
    m1 = merge_enabled(d[1], d[5], 4'b1000);
    add_entry(OP_WRITE, a0, 4'hf, d[0], 0);
    add_entry(OP_READ,  a0, 4'hf, 0, d[0]);
    add_entry(OP_WRITE, a1, 4'hf, d[1], 0);
    add_entry(OP_WRITE, a2, 4'hf, d[2], 0);
    add_entry(OP_WRITE, a3, 4'hf, d[3], 0);
    add_entry(OP_READ,  a0, 4'hf, 0, d[0]);
    add_entry(OP_READ,  a1, 4'hf, 0, d[1]);
    add_entry(OP_READ,  a2, 4'hf, 0, d[2]);
    add_entry(OP_READ,  a3, 4'hf, 0, d[3]);
    add_entry(OP_WRITE, a0, 4'b0101, d[4], 0);
    add_entry(OP_READ,  a0, 4'hf, 0, m0);
    add_entry(OP_WRITE, a1, 4'b1000, d[5], 0);
    add_entry(OP_READ,  a1, 4'hf, 0, m1);
    add_entry(OP_IDLE,  0, 4'h1, 3000, 0);
    add_entry(OP_CFG,   0, 4'h0, 100, 0);
    // The old countdown runs out before the next window opens.
    add_entry(OP_IDLE,  0, 4'h0, 400, 0);
    add_entry(OP_IDLE,  0, 4'h1, 3000, 0);
    add_entry(OP_CFG,   1, 4'h0, 3, 0);
    add_entry(OP_READ,  a2, 4'hf, 0, d[2]);
    add_entry(OP_WRITE, a3, 4'hf, d[6], 0);
    add_entry(OP_READ,  a3, 4'hf, 0, d[6]);
    add_entry(OP_CFG,   1, 4'h0, 5, 0);
    add_entry(OP_READ,  a0, 4'hf, 0, m0);
    // Short interval keeps a refresh pending between back-to-back requests.
    add_entry(OP_CFG,   0, 4'h0, 20, 0);
    add_entry(OP_WRITE, a2, 4'hf, d[7], 0);
    add_entry(OP_READ,  a2, 4'hf, 0, d[7]);
    add_entry(OP_WRITE, a4, 4'hf, d[8], 0);
    add_entry(OP_READ,  a4, 4'hf, 0, d[8]);
    add_entry(OP_READ,  a1, 4'hf, 0, m1);
    add_entry(OP_READ,  a0, 4'hf, 0, m0);
  endtask

  task automatic wait_for_init();
    int n;
    n = 0;
    while (!init_done && n < INIT_TIMEOUT) begin
      @(negedge cpu_clk);
      n++;
    end
    if (!init_done) begin
      $display("Timeout: the power-up sequence did not finish in %0d cycles", INIT_TIMEOUT);
      tb_errors++;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    int n;
    @(negedge cpu_clk);
    read  = 1'b0;
    write = 1'b0;
    case (e.op)
      OP_WRITE, OP_READ: begin
        read     = (e.op == OP_READ);
        write    = (e.op == OP_WRITE);
        address  = e.addr;
        be       = e.be;
        data_in  = e.data;
        exp_data = e.exp_rd;
        // Fields stay put through the ready cycle.
        n = 0;
        do begin
          @(negedge cpu_clk);
          n++;
        end while (!ready && n < READY_TIMEOUT);
        if (!ready) begin
          $display("Timeout: no ready for the %s of address 0x%h",
                   e.op == OP_READ ? "read" : "write", e.addr);
          tb_errors++;
        end
      end
      OP_CFG: begin
        cfg_write = 1'b1;
        cfg_sel   = e.addr[0];
        cfg_wdata = e.data[15:0];
        @(negedge cpu_clk);
        cfg_write = 1'b0;
      end
      default: begin
        measure = e.be[0];
        repeat (e.data) @(negedge cpu_clk);
        measure = 1'b0;
      end
    endcase
  endtask

  initial begin : run
    int total;
    reset_n    = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    address    = '0;
    data_in    = '0;
    be         = '0;
    cfg_write  = 1'b0;
    cfg_sel    = 1'b0;
    cfg_wdata  = '0;
    exp_data   = '0;
    measure    = 1'b0;
    tb_errors  = 0;
    lfsr_state = 32'hc13a_d6e5;
    build_table();
    repeat (16) @(negedge cpu_clk);
    reset_n = 1'b1;
    wait_for_init();
    foreach (stim_q[i])
      apply_entry(stim_q[i]);
    @(negedge cpu_clk);
    read  = 1'b0;
    write = 1'b0;
    repeat (20) @(negedge cpu_clk);
    total = chk_errors + tb_errors + uut.u_fsm.u_asserts.fail_count;
    $display("Tests finished: %0d, errors: %0d", chk_tests, total);
    if (total == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: sdram_timing_pkg.sv
package sdram_timing_pkg;

  // Power-up. Short wait for simulation.
  localparam logic [15:0] INIT_WAIT_CYCLES = 16'd200;
  localparam logic [3:0]  INIT_REFRESHES   = 4'd8;

  // Command spacing in cpu_clk cycles.
  localparam logic [3:0] T_RCD        = 4'd2;
  localparam logic [3:0] T_RP         = 4'd2;
  localparam logic [3:0] T_RFC        = 4'd7;
  localparam logic [3:0] T_MRD        = 4'd2;
  localparam logic [3:0] T_WR_RECOVER = 4'd3;

  // Configuration defaults.
  localparam logic [15:0] REFRESH_INTERVAL_RESET = 16'd390;
  localparam logic [1:0]  CAS_LATENCY_RESET      = 2'd2;

  // CPU address split.
  localparam int BANK_MSB = 24;
  localparam int BANK_LSB = 23;
  localparam int ROW_MSB  = 22;
  localparam int ROW_LSB  = 10;
  localparam int COL_MSB  = 9;

endpackage

// File: verilog.f
sdram_cmd_pkg.sv
sdram_timing_pkg.sv
sdram_config_regs.sv
sdram_refresh_timer.sv
sdram_init_seq.sv
sdram_cmd_fsm.sv
sdram_controller.sv
sdram_asserts.sv
sdram_checker.sv
sdram_tb.sv
